//--- design/tofHist_macros.svh
`ifndef TOF_HIST_MACROS_SVH
`define TOF_HIST_MACROS_SVH

// coarse TDC timestamp width
`define TOF_TS_BITS 10

// bin address width, 32 bins per histogram
// coarse bin is the upper timestamp field
`define TOF_BIN_BITS 5

// per-bin counter width, saturates at all ones
`define TOF_COUNT_BITS 6

// samples consumed per pass, discarded ones included
`define TOF_ACQ_LEN 96

// intake FIFO depth
// also the credits the source starts with
`define TOF_CREDITS 4

`endif

//--- design/tofHistPkg.sv
`include "tofHist_macros.svh"

package tofHistPkg;

    // one raw timestamp or one final estimate
    typedef logic [`TOF_TS_BITS-1:0] timestamp_t;

    // histogram bin index
    typedef logic [`TOF_BIN_BITS-1:0] binAddr_t;

    // occupancy of a single bin
    typedef logic [`TOF_COUNT_BITS-1:0] binCount_t;

    // which histogram pass is running
    // coarse pass bins on the upper field
    // fine pass bins on the lower field inside the window
    typedef enum logic {
        PH_COARSE,
        PH_FINE
    } phase_t;

endpackage

//--- design/sampleIntake.sv
`timescale 1ns/1ps
`include "tofHist_macros.svh"

module sampleIntake (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   tsValid,
    input  tofHistPkg::timestamp_t ts,
    input  logic                   samplePop,
    input  tofHistPkg::phase_t     phase,
    input  tofHistPkg::binAddr_t   windowBin,
    output logic                   tsCredit,
    output logic                   sampleReady,
    output tofHistPkg::binAddr_t   sampleBin,
    output logic                   sampleInWindow
);
    import tofHistPkg::*;

    localparam int fifoDepth = `TOF_CREDITS;
    localparam int ptrBits = $clog2(fifoDepth);
    localparam int fillBits = $clog2(fifoDepth + 1);

    // sample storage, payload only
    timestamp_t          fifoMem [fifoDepth];
    logic [ptrBits-1:0]  wrPtr;
    logic [ptrBits-1:0]  rdPtr;
    logic [fillBits-1:0] fillCount;

    // head entry split into its two bin fields
    timestamp_t headTs;
    binAddr_t   headCoarse;
    binAddr_t   headFine;

    // pointer advance with wrap at depth
    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        return (ptr == ptrBits'(fifoDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // one credit back per sample leaving the FIFO
    assign tsCredit = samplePop;
    assign sampleReady = (fillCount != '0);

    always_ff @(posedge clk) begin
        if (tsValid) begin
            fifoMem[wrPtr] <= ts;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (tsValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (samplePop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // simultaneous push and pop leaves occupancy unchanged
            case ({tsValid, samplePop})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    assign headTs     = fifoMem[rdPtr];
    assign headCoarse = headTs[`TOF_TS_BITS-1 -: `TOF_BIN_BITS];
    assign headFine   = headTs[`TOF_BIN_BITS-1:0];

    // map at pop time with the phase in force right now
    always_comb begin
        if (phase == PH_COARSE) begin
            sampleBin      = headCoarse;
            sampleInWindow = 1'b1;
        end else begin
            // fine pass keeps only samples in the coarse window
            sampleBin      = headFine;
            sampleInWindow = (headCoarse == windowBin);
        end
    end

    // source overran its credits
    // a pop in the same cycle frees the slot being written
    assert property (@(posedge clk) disable iff (!rstN)
        tsValid |-> (fillCount < fillBits'(fifoDepth)) || samplePop)
        else $error("sampleIntake: sample written while FIFO full");

    // builder popped with nothing stored
    assert property (@(posedge clk) disable iff (!rstN)
        samplePop |-> sampleReady)
        else $error("sampleIntake: pop from empty FIFO");

endmodule

//--- design/histogramBuilder.sv
`timescale 1ns/1ps
`include "tofHist_macros.svh"

module histogramBuilder (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  sampleReady,
    input  tofHistPkg::binAddr_t  sampleBin,
    input  logic                  sampleInWindow,
    input  tofHistPkg::phase_t    phase,
    input  logic                  scanRead,
    input  tofHistPkg::binAddr_t  scanAddr,
    input  logic                  peakDone,
    output logic                  samplePop,
    output logic                  scanStart,
    output tofHistPkg::binCount_t scanCount
);
    import tofHistPkg::*;

    // accumulate reads a bin, write stores it back, scan hands bins out
    typedef enum logic [1:0] {
        ACCUM,
        WRITE,
        SCAN
    } buildState_t;

    localparam int numBins = 1 << `TOF_BIN_BITS;
    localparam int popBits = $clog2(`TOF_ACQ_LEN + 1);

    buildState_t        state;
    binCount_t          binMem [numBins];
    logic [popBits-1:0] popCount;
    logic               acqDone;

    // sample in flight between read and write
    binAddr_t  curBin;
    logic      curInWindow;
    binCount_t curCount;

    // pop only from accumulate and only with data waiting
    assign samplePop = (state == ACCUM) && sampleReady;
    assign acqDone   = (popCount == popBits'(`TOF_ACQ_LEN));

    // async read port for the peak sweep
    assign scanCount = binMem[scanAddr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= ACCUM;
            popCount  <= '0;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                ACCUM: begin
                    if (samplePop) begin
                        state    <= WRITE;
                        popCount <= popCount + 1'b1;
                    end
                end
                WRITE: begin
                    // last write of the pass lands this cycle
                    if (acqDone) begin
                        state     <= SCAN;
                        scanStart <= 1'b1;
                    end else begin
                        state <= ACCUM;
                    end
                end
                SCAN: begin
                    // phase flips on the same edge
                    if (peakDone) begin
                        state    <= ACCUM;
                        popCount <= '0;
                    end
                end
                default: state <= ACCUM;
            endcase
        end
    end

    // capture the popped sample and its bin's current count
    always_ff @(posedge clk) begin
        if (samplePop) begin
            curBin      <= sampleBin;
            curInWindow <= sampleInWindow;
            curCount    <= binMem[sampleBin];
        end
    end

    // bin memory with reset clear
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numBins; i++) begin
                binMem[i] <= '0;
            end
        end else if (state == WRITE) begin
            // out-of-window pops burn the slot, no write
            if (curInWindow && (curCount != '1)) begin
                binMem[curBin] <= curCount + 1'b1;
            end
        end else if ((state == SCAN) && scanRead) begin
            // read and clear, ready for the next pass
            binMem[scanAddr] <= '0;
        end
    end

    // phase must hold from pop through the write
    assert property (@(posedge clk) disable iff (!rstN)
        samplePop |=> $stable(phase))
        else $error("histogramBuilder: phase changed under a sample in flight");

    // detector may only sweep while accumulation is parked
    assert property (@(posedge clk) disable iff (!rstN)
        scanRead |-> (state == SCAN))
        else $error("histogramBuilder: scan read outside SCAN");

endmodule

//--- design/peakDetector.sv
`timescale 1ns/1ps

module peakDetector (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  scanStart,
    input  tofHistPkg::binCount_t scanCount,
    output logic                  scanRead,
    output tofHistPkg::binAddr_t  scanAddr,
    output logic                  peakDone,
    output tofHistPkg::binAddr_t  peakBin
);
    import tofHistPkg::*;

    typedef enum logic {
        IDLE,
        SWEEP
    } sweepState_t;

    // final bin of a sweep
    localparam binAddr_t lastAddr = '1;

    sweepState_t state;
    binAddr_t    addrReg;
    binCount_t   maxCount;
    binAddr_t    maxBin;

    assign scanRead = (state == SWEEP);
    assign scanAddr = addrReg;
    assign peakBin  = maxBin;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            addrReg  <= '0;
            maxCount <= '0;
            maxBin   <= '0;
            peakDone <= 1'b0;
        end else begin
            peakDone <= 1'b0;
            case (state)
                IDLE: begin
                    // empty histogram falls back to bin 0
                    if (scanStart) begin
                        state    <= SWEEP;
                        addrReg  <= '0;
                        maxCount <= '0;
                        maxBin   <= '0;
                    end
                end
                SWEEP: begin
                    // strictly greater only, so ties stay on the lower index
                    if (scanCount > maxCount) begin
                        maxCount <= scanCount;
                        maxBin   <= addrReg;
                    end
                    if (addrReg == lastAddr) begin
                        state    <= IDLE;
                        peakDone <= 1'b1;
                    end else begin
                        addrReg <= addrReg + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // builder must not request a new sweep mid-sweep
    assert property (@(posedge clk) disable iff (!rstN)
        scanStart |-> (state == IDLE))
        else $error("peakDetector: scanStart during sweep");

endmodule

//--- design/phaseController.sv
`timescale 1ns/1ps

module phaseController (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   peakDone,
    input  tofHistPkg::binAddr_t   peakBin,
    output tofHistPkg::phase_t     phase,
    output tofHistPkg::binAddr_t   windowBin,
    output logic                   resultValid,
    output tofHistPkg::timestamp_t result
);
    import tofHistPkg::*;

    // pass sequencing and window hold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase       <= PH_COARSE;
            windowBin   <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            if (peakDone) begin
                if (phase == PH_COARSE) begin
                    // coarse peak becomes the fine window
                    windowBin <= peakBin;
                    phase     <= PH_FINE;
                end else begin
                    // measurement complete
                    resultValid <= 1'b1;
                    phase       <= PH_COARSE;
                end
            end
        end
    end

    // estimate is window base plus fine offset
    // only meaningful while resultValid is high
    always_ff @(posedge clk) begin
        if (peakDone && (phase == PH_FINE)) begin
            result <= {windowBin, peakBin};
        end
    end

endmodule

//--- design/tofHistTop.sv
`timescale 1ns/1ps

module tofHistTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   tsValid,
    input  tofHistPkg::timestamp_t ts,
    output logic                   tsCredit,
    output logic                   resultValid,
    output tofHistPkg::timestamp_t result
);
    import tofHistPkg::*;

    // intake to builder
    logic     sampleReady;
    binAddr_t sampleBin;
    logic     sampleInWindow;
    logic     samplePop;

    // builder and detector sweep
    logic      scanStart;
    logic      scanRead;
    binAddr_t  scanAddr;
    binCount_t scanCount;

    // detector result and pass control
    logic     peakDone;
    binAddr_t peakBin;
    phase_t   phase;
    binAddr_t windowBin;

    sampleIntake sampleIntakeU0 (
        .clk           (clk),
        .rstN          (rstN),
        .tsValid       (tsValid),
        .ts            (ts),
        .samplePop     (samplePop),
        .phase         (phase),
        .windowBin     (windowBin),
        .tsCredit      (tsCredit),
        .sampleReady   (sampleReady),
        .sampleBin     (sampleBin),
        .sampleInWindow(sampleInWindow)
    );

    histogramBuilder histogramBuilderU0 (
        .clk           (clk),
        .rstN          (rstN),
        .sampleReady   (sampleReady),
        .sampleBin     (sampleBin),
        .sampleInWindow(sampleInWindow),
        .phase         (phase),
        .scanRead      (scanRead),
        .scanAddr      (scanAddr),
        .peakDone      (peakDone),
        .samplePop     (samplePop),
        .scanStart     (scanStart),
        .scanCount     (scanCount)
    );

    peakDetector peakDetectorU0 (
        .clk      (clk),
        .rstN     (rstN),
        .scanStart(scanStart),
        .scanCount(scanCount),
        .scanRead (scanRead),
        .scanAddr (scanAddr),
        .peakDone (peakDone),
        .peakBin  (peakBin)
    );

    phaseController phaseControllerU0 (
        .clk        (clk),
        .rstN       (rstN),
        .peakDone   (peakDone),
        .peakBin    (peakBin),
        .phase      (phase),
        .windowBin  (windowBin),
        .resultValid(resultValid),
        .result     (result)
    );

endmodule

//--- bench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk
);

    // half of the 20 ns period
    localparam int halfPeriod = 10;

    // free running from time zero
    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

//--- bench/tofHistTb.sv
`timescale 1ns/1ps
`include "tofHist_macros.svh"

module tofHistTb;
    import tofHistPkg::*;

    localparam int numBins = 1 << `TOF_BIN_BITS;
    localparam int satCount = (1 << `TOF_COUNT_BITS) - 1;
    localparam int measLen = 2 * `TOF_ACQ_LEN;
    // stimulus shapes
    localparam int modeCluster = 0;
    localparam int modeReject = 1;
    localparam int modeTie = 2;
    localparam int modeBurst = 3;
    // seven full measurements plus one cut short by reset
    localparam int numMeas = 8;
    localparam int watchdogCycles = numMeas * 2 * `TOF_ACQ_LEN * 4 + 2000;

    logic       clk;
    logic       rstN;
    logic       tsValid;
    timestamp_t ts;
    logic       tsCredit;
    logic       resultValid;
    timestamp_t result;

    integer seed = 32'h5f0a;
    int     errors;
    int     checks;
    // source side credit bookkeeping since the last reset
    int     credits;
    int     creditPulses;
    int     sentCount;
    int     resultsSeen;
    int     lastResult;
    logic   sawStall;

    // reference model of two saturating histograms
    int         coarseHist [numBins];
    int         fineHist [numBins];
    binAddr_t   modelWindow;
    int         measIdx;
    timestamp_t expQ [$];

    // shape of the measurement being sent
    timestamp_t center;
    binAddr_t   tieLo;
    binAddr_t   tieHi;

    clockGen clockGenU0 (
        .clk(clk)
    );

    tofHistTop DUT (
        .clk        (clk),
        .rstN       (rstN),
        .tsValid    (tsValid),
        .ts         (ts),
        .tsCredit   (tsCredit),
        .resultValid(resultValid),
        .result     (result)
    );

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // lowest index wins on equal counts
    function automatic binAddr_t argmaxBin(input int hist [numBins]);
        binAddr_t best;
        int       bestCount;
        best = '0;
        bestCount = 0;
        for (int i = 0; i < numBins; i++) begin
            if (hist[i] > bestCount) begin
                bestCount = hist[i];
                best = binAddr_t'(i);
            end
        end
        return best;
    endfunction

    function automatic void modelReset();
        for (int i = 0; i < numBins; i++) begin
            coarseHist[i] = 0;
            fineHist[i] = 0;
        end
        modelWindow = '0;
        measIdx = 0;
    endfunction

    // samples fall into passes strictly in send order
    function automatic void modelAdd(input timestamp_t t);
        binAddr_t hi;
        binAddr_t lo;
        hi = t[`TOF_TS_BITS-1 -: `TOF_BIN_BITS];
        lo = t[`TOF_BIN_BITS-1:0];
        if (measIdx < `TOF_ACQ_LEN) begin
            if (coarseHist[hi] < satCount) begin
                coarseHist[hi]++;
            end
        end else if (hi == modelWindow) begin
            if (fineHist[lo] < satCount) begin
                fineHist[lo]++;
            end
        end
        // out-of-window fine samples still use up a slot
        measIdx++;
        if (measIdx == `TOF_ACQ_LEN) begin
            modelWindow = argmaxBin(coarseHist);
        end
        if (measIdx == measLen) begin
            expQ.push_back({modelWindow, argmaxBin(fineHist)});
            modelReset();
        end
    endfunction

    function automatic timestamp_t makeSample(input int mode);
        timestamp_t near;
        timestamp_t s;
        // jitter of +-3 codes around the center
        near = center + timestamp_t'(randBelow(7)) - timestamp_t'(3);
        case (mode)
            modeReject: begin
                // half of the fine pass lands in the opposite half of the range
                if (measIdx >= `TOF_ACQ_LEN && randBelow(2) == 1) begin
                    s = near ^ timestamp_t'(1 << (`TOF_TS_BITS - 1));
                end else begin
                    s = near;
                end
            end
            modeTie: begin
                if (measIdx < `TOF_ACQ_LEN) begin
                    // 70 in the upper bin would wrap to 6 without saturation
                    if (measIdx < 70) begin
                        s = {tieHi, binAddr_t'(randBelow(numBins))};
                    end else begin
                        s = {tieLo, binAddr_t'(randBelow(numBins))};
                    end
                end else begin
                    // even split over two fine bins in the window
                    s = {tieHi, (measIdx[0] ? tieHi : tieLo)};
                end
            end
            default: begin
                // one in eight is uniform background
                if (randBelow(8) == 0) begin
                    s = timestamp_t'(randBelow(1 << `TOF_TS_BITS));
                end else begin
                    s = near;
                end
            end
        endcase
        return s;
    endfunction

    task automatic checkValue(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic checkResult();
        timestamp_t expected;
        resultsSeen++;
        lastResult = int'(result);
        checks++;
        assert (expQ.size() > 0) else begin
            errors++;
            $display("resultValid at %0t with no measurement completed by the model", $time);
        end
        if (expQ.size() > 0) begin
            expected = expQ.pop_front();
            checkValue("result", int'(expected), int'(result));
        end
    endtask

    // advance one falling edge and collect returned credits and results
    task automatic stepCycle();
        @(negedge clk);
        tsValid = 1'b0;
        if (tsCredit) begin
            credits++;
            creditPulses++;
        end
        checks++;
        assert (credits >= 0 && credits <= `TOF_CREDITS) else begin
            errors++;
            $display("[ERROR] %0t credits expected 0..%0d got %0d",
                $time, `TOF_CREDITS, credits);
        end
        if (resultValid) begin
            checkResult();
        end
    endtask

    task automatic sendSample(input int mode, input logic mayIdle);
        timestamp_t s;
        stepCycle();
        // hold off without a credit and idle now and then
        while (credits == 0 || (mayIdle && randBelow(4) == 0)) begin
            if (credits == 0) begin
                sawStall = 1'b1;
            end
            stepCycle();
        end
        s = makeSample(mode);
        modelAdd(s);
        ts = s;
        tsValid = 1'b1;
        credits--;
        sentCount++;
    endtask

    task automatic runMeasurement(input int mode, input int numSamples);
        center = timestamp_t'(randBelow(1 << `TOF_TS_BITS));
        tieLo = binAddr_t'(randBelow(numBins - 1));
        tieHi = tieLo + binAddr_t'(1 + randBelow(numBins - 1 - int'(tieLo)));
        for (int i = 0; i < numSamples; i++) begin
            sendSample(mode, mode != modeBurst);
        end
    endtask

    // step until every modeled result has come out
    task automatic waitResults();
        while (expQ.size() > 0) begin
            stepCycle();
        end
    endtask

    task automatic applyReset();
        stepCycle();
        rstN = 1'b0;
        // everything in flight is lost and the source gets its credits back
        credits = `TOF_CREDITS;
        creditPulses = 0;
        sentCount = 0;
        expQ.delete();
        modelReset();
        repeat (8) begin
            stepCycle();
        end
        rstN = 1'b1;
    endtask

    initial begin
        int resultsBefore;
        rstN = 1'b0;
        tsValid = 1'b0;
        ts = '0;
        errors = 0;
        checks = 0;
        resultsSeen = 0;
        lastResult = 0;
        sawStall = 1'b0;
        applyReset();

        runMeasurement(modeCluster, measLen);
        runMeasurement(modeCluster, measLen);
        runMeasurement(modeReject, measLen);
        runMeasurement(modeTie, measLen);
        waitResults();
        // upper coarse bin saturates and the fine bins tie
        checkValue("tie result", int'({tieHi, tieLo}), lastResult);

        // source outruns the builder while scans hold samples back
        sawStall = 1'b0;
        runMeasurement(modeBurst, measLen);
        checks++;
        assert (sawStall) else begin
            errors++;
            $display("burst measurement never ran out of credits at %0t", $time);
        end

        // reset lands inside the fine pass
        runMeasurement(modeCluster, measLen - 42);
        waitResults();
        applyReset();
        resultsBefore = resultsSeen;
        runMeasurement(modeCluster, measLen);
        waitResults();
        checkValue("results after reset", resultsBefore + 1, resultsSeen);
        runMeasurement(modeReject, measLen);
        waitResults();

        // drain and balance the credits
        repeat (20) begin
            stepCycle();
        end
        checkValue("tsCredit pulses", sentCount, creditPulses);
        checkValue("credits", `TOF_CREDITS, credits);

        $display("checks: %0d errors: %0d results: %0d", checks, errors, resultsSeen);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // run length bound
    initial begin
        repeat (watchdogCycles) begin
            @(posedge clk);
        end
        $display("watchdog expired after %0d cycles, the run did not complete",
            watchdogCycles);
        $display("checks: %0d errors: %0d results: %0d", checks, errors, resultsSeen);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/tofHistPkg.sv
design/sampleIntake.sv
design/histogramBuilder.sv
design/peakDetector.sv
design/phaseController.sv
design/tofHistTop.sv
bench/clockGen.sv
bench/tofHistTb.sv

//--- Makefile
TOP = tofHistTb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
